/* src.f */
fixed_point_pkg.sv
solver_pkg.sv
pivot_select.sv
row_normalize.sv
row_eliminate.sv
back_substitute.sv
fallback_result.sv
gauss_solver_top.sv
tb_clock_gen.sv
tb_gauss_solver.sv

/* Bender.yml */
package:
  name: gauss_solver

sources:
  - fixed_point_pkg.sv
  - solver_pkg.sv
  - pivot_select.sv
  - row_normalize.sv
  - row_eliminate.sv
  - back_substitute.sv
  - fallback_result.sv
  - gauss_solver_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_gauss_solver.sv

/* tb_gauss_solver.sv */
`timescale 1ns/10ps

module tb_gauss_solver;
    import fixed_point_pkg::*;
    import solver_pkg::*;

    localparam int SCALE       = 65536;
    localparam int TOL         = 64;
    localparam int DRAIN_LIMIT = SOLVE_LATENCY + 40;
    localparam int RESET_LIMIT = 30;

    logic     clk;
    logic     rst_n;
    logic     valid_in;
    aug_mat_t mat;
    logic     valid_out;
    beta_t    beta;
    logic     singular_err;

    integer seed         = 92791;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycle_cnt    = 0;

    // system being built, integer units
    int a_coef [3][3];
    int rhs [3];
    int beta_true [3];

    // items in flight, oldest first
    int    exp_stamp [$];
    beta_t exp_beta [$];
    bit    exp_sing [$];

    bit    err_expected = 1'b0;
    beta_t last_beta    = '0;

    tb_clock_gen u_clk_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    gauss_solver_top uut (
        .clk(clk),
        .rst_n(rst_n),
        .valid_in(valid_in),
        .mat(mat),
        .valid_out(valid_out),
        .beta(beta),
        .singular_err(singular_err)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic bit within_tol(input fx_t got, input fx_t want);
        longint diff;
        diff = longint'(got) - longint'(want);
        return (diff <= TOL) && (diff >= -TOL);
    endfunction

    // --------------------
    // system builders
    // --------------------
    // b = A * beta, so the exact solution is known
    task automatic make_rhs();
        for (int i = 0; i < 3; i++) begin
            rhs[i] = 0;
            for (int j = 0; j < 3; j++) begin
                rhs[i] += a_coef[i][j] * beta_true[j];
            end
        end
    endtask

    task automatic random_beta();
        for (int i = 0; i < 3; i++) begin
            beta_true[i] = $random(seed) % 8;
        end
    endtask

    // symmetric, dominant by rows and by columns
    task automatic random_dominant_system();
        int off;
        for (int i = 0; i < 3; i++) begin
            for (int j = i + 1; j < 3; j++) begin
                a_coef[i][j] = $random(seed) % 5;
                a_coef[j][i] = a_coef[i][j];
            end
        end
        for (int i = 0; i < 3; i++) begin
            off = 0;
            for (int j = 0; j < 3; j++) begin
                if (j != i) begin
                    off += (a_coef[i][j] < 0) ? -a_coef[i][j] : a_coef[i][j];
                end
            end
            a_coef[i][i] = ($random(seed) & 1) ? -(off + 2) : (off + 2);
        end
        random_beta();
        make_rhs();
    endtask

    // moves the dominant entries off the diagonal
    task automatic rotate_rows(input int by);
        int tmp [3][3];
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                tmp[i][j] = a_coef[i][j];
            end
        end
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                a_coef[i][j] = tmp[(i + by) % 3][j];
            end
        end
        make_rhs();
    endtask

    task automatic set_row(input int r, input int c0, input int c1, input int c2);
        a_coef[r][0] = c0;
        a_coef[r][1] = c1;
        a_coef[r][2] = c2;
    endtask

    // --------------------
    // driving and waiting
    // --------------------
    task automatic send_item(input bit singular);
        aug_mat_t m;
        beta_t    want;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                m[i][j] = a_coef[i][j] * SCALE;
            end
            m[i][3] = rhs[i] * SCALE;
        end
        want = '0;
        if (singular) begin
            // mean of the raw row 0, other betas zero
            want[0] = $rtoi($itor(rhs[0]) / $itor(a_coef[0][0]) * SCALE);
        end else begin
            for (int i = 0; i < 3; i++) begin
                want[i] = beta_true[i] * SCALE;
            end
        end
        @(posedge clk);
        valid_in <= 1'b1;
        mat      <= m;
        // number of the clock period that starts at this edge
        exp_stamp.push_back(cycle_cnt + 1);
        exp_beta.push_back(want);
        exp_sing.push_back(singular);
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released, gave up at %0t", $time);
            other_errors++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_stamp.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_stamp.size() != 0) begin
            $display("timed out at %0t with %0d results still missing", $time, exp_stamp.size());
            other_errors++;
            exp_stamp.delete();
            exp_beta.delete();
            exp_sing.delete();
        end
    endtask

    // --------------------
    // output checks
    // --------------------
    // outputs move on the rising edge, so they are sampled on the falling one
    always @(negedge clk) begin : check_outputs
        beta_t want;
        int    stamp;
        bit    sing;
        if (rst_n) begin
            if (valid_out) begin
                if (exp_stamp.size() == 0) begin
                    $display("valid_out pulsed at %0t with no item in flight", $time);
                    other_errors++;
                end else begin
                    stamp = exp_stamp.pop_front();
                    want  = exp_beta.pop_front();
                    sing  = exp_sing.pop_front();
                    if (sing) begin
                        err_expected = 1'b1;
                    end
                    assert (cycle_cnt - stamp == SOLVE_LATENCY) else begin
                        $display("FAIL %0t valid_out latency: expected %0d, got %0d",
                                 $time, SOLVE_LATENCY, cycle_cnt - stamp);
                        value_errors++;
                    end
                    for (int i = 0; i < N_ROWS; i++) begin
                        assert (within_tol(beta[i], want[i])) else begin
                            $display("FAIL %0t beta[%0d]: expected %0d, got %0d",
                                     $time, i, $signed(want[i]), $signed(beta[i]));
                            value_errors++;
                        end
                    end
                end
                last_beta = beta;
            end else begin
                assert (beta == last_beta) else begin
                    $display("FAIL %0t beta (held): expected %h, got %h", $time, last_beta, beta);
                    value_errors++;
                end
            end
            assert (singular_err == err_expected) else begin
                $display("FAIL %0t singular_err: expected %b, got %b",
                         $time, err_expected, singular_err);
                value_errors++;
            end
        end
    end

    initial begin
        valid_in = 1'b0;
        mat      = '0;
        wait_reset_release();

        // reset state, before any input
        @(negedge clk);
        assert (valid_out == 1'b0) else begin
            $display("FAIL %0t valid_out: expected 0, got %b", $time, valid_out);
            value_errors++;
        end
        assert (singular_err == 1'b0) else begin
            $display("FAIL %0t singular_err: expected 0, got %b", $time, singular_err);
            value_errors++;
        end
        assert (beta == '0) else begin
            $display("FAIL %0t beta: expected 0, got %h", $time, beta);
            value_errors++;
        end

        // single dominant systems with gaps
        repeat (6) begin
            random_dominant_system();
            send_item(1'b0);
            go_idle(3);
        end
        wait_drain();

        // zero at row 0 column 0
        set_row(0, 0, 1, 2);
        set_row(1, 1, 0, 1);
        set_row(2, 2, 1, 0);
        random_beta();
        make_rhs();
        send_item(1'b0);
        go_idle(2);
        // second pivot is zero until rows 1 and 2 swap
        set_row(0, 1, 2, 3);
        set_row(1, 2, 4, 7);
        set_row(2, 1, 3, 2);
        random_beta();
        make_rhs();
        send_item(1'b0);
        go_idle(2);
        repeat (4) begin
            random_dominant_system();
            rotate_rows(1 + ($random(seed) & 1));
            send_item(1'b0);
            go_idle(1);
        end
        wait_drain();

        // back-to-back burst
        repeat (8) begin
            random_dominant_system();
            send_item(1'b0);
        end
        go_idle(1);
        wait_drain();

        // rows 1 and 2 equal, then a regular item right behind
        set_row(0, 2, 1, 1);
        set_row(1, 1, 1, 1);
        set_row(2, 1, 1, 1);
        rhs[0] = 8;
        rhs[1] = 6;
        rhs[2] = 6;
        send_item(1'b1);
        set_row(0, 1, 2, 3);
        set_row(1, 2, 2, 2);
        set_row(2, 2, 2, 2);
        rhs[0] = 5;
        rhs[1] = 4;
        rhs[2] = 4;
        send_item(1'b1);
        random_dominant_system();
        send_item(1'b0);
        go_idle(1);
        wait_drain();
        // flag must stay up with nothing in flight
        go_idle(5);

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a rising edge after the reset cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* gauss_solver_top.sv */
`timescale 1ns/10ps

module gauss_solver_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  solver_pkg::aug_mat_t mat,
    output logic                 valid_out,
    output solver_pkg::beta_t    beta,
    output logic                 singular_err
);
    import solver_pkg::*;

    // stage outputs, in pipeline order
    logic     v_piv0, v_nrm0, v_elm0, v_piv1, v_nrm1, v_elm1, v_nrm2, v_bks;
    logic     s_piv0, s_nrm0, s_elm0, s_piv1, s_nrm1, s_elm1, s_nrm2, s_bks;
    aug_mat_t m_piv0, m_nrm0, m_elm0, m_piv1, m_nrm1, m_elm1, m_nrm2;
    beta_t    beta_bks;

    // --------------------
    // column 0
    // --------------------
    pivot_select #(.COL(0)) u_pivot0 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(valid_in), .mat_in(mat), .singular_in(1'b0),
        .valid_out(v_piv0), .mat_out(m_piv0), .singular_out(s_piv0)
    );

    row_normalize #(.ROW(0)) u_norm0 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_piv0), .mat_in(m_piv0), .singular_in(s_piv0),
        .valid_out(v_nrm0), .mat_out(m_nrm0), .singular_out(s_nrm0)
    );

    row_eliminate #(.COL(0)) u_elim0 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_nrm0), .mat_in(m_nrm0), .singular_in(s_nrm0),
        .valid_out(v_elm0), .mat_out(m_elm0), .singular_out(s_elm0)
    );

    // --------------------
    // column 1
    // --------------------
    pivot_select #(.COL(1)) u_pivot1 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_elm0), .mat_in(m_elm0), .singular_in(s_elm0),
        .valid_out(v_piv1), .mat_out(m_piv1), .singular_out(s_piv1)
    );

    row_normalize #(.ROW(1)) u_norm1 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_piv1), .mat_in(m_piv1), .singular_in(s_piv1),
        .valid_out(v_nrm1), .mat_out(m_nrm1), .singular_out(s_nrm1)
    );

    row_eliminate #(.COL(1)) u_elim1 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_nrm1), .mat_in(m_nrm1), .singular_in(s_nrm1),
        .valid_out(v_elm1), .mat_out(m_elm1), .singular_out(s_elm1)
    );

    // last row needs no pivot search, only one candidate left
    row_normalize #(.ROW(2)) u_norm2 (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_elm1), .mat_in(m_elm1), .singular_in(s_elm1),
        .valid_out(v_nrm2), .mat_out(m_nrm2), .singular_out(s_nrm2)
    );

    // --------------------
    // solution
    // --------------------
    back_substitute u_back (
        .clk(clk), .rst_n(rst_n),
        .valid_in(v_nrm2), .mat_in(m_nrm2), .singular_in(s_nrm2),
        .valid_out(v_bks), .beta_out(beta_bks), .singular_out(s_bks)
    );

    fallback_result u_result (
        .clk(clk), .rst_n(rst_n),
        .first_row(mat[0]),
        .valid_in(v_bks), .beta_in(beta_bks), .singular_in(s_bks),
        .valid_out(valid_out), .beta(beta), .singular_err(singular_err)
    );

endmodule

/* fallback_result.sv */
`timescale 1ns/10ps

module fallback_result (
    input  logic              clk,
    input  logic              rst_n,
    input  solver_pkg::row_t  first_row,
    input  logic              valid_in,
    input  solver_pkg::beta_t beta_in,
    input  logic              singular_in,
    output logic              valid_out,
    output solver_pkg::beta_t beta,
    output logic              singular_err
);
    import fixed_point_pkg::*;
    import solver_pkg::*;

    fx_t   mean_now;
    fx_t   mean_pipe [MEAN_DELAY];
    beta_t fallback;

    // --------------------
    // mean path
    // --------------------
    // rhs over the first diagonal entry of the raw input row 0
    assign mean_now = fx_div(first_row[N_COLS-1], first_row[0]);

    always_ff @(posedge clk) begin
        mean_pipe[0] <= mean_now;
        for (int i = 1; i < MEAN_DELAY; i++) begin
            mean_pipe[i] <= mean_pipe[i-1];
        end
    end

    // mean in slot 0, other betas zero
    always_comb begin
        fallback    = '0;
        fallback[0] = mean_pipe[MEAN_DELAY-1];
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            beta      <= '0;
        end else begin
            valid_out <= valid_in;
            // beta only moves with a result, holds otherwise
            if (valid_in) begin
                beta <= singular_in ? fallback : beta_in;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            singular_err <= 1'b0;
        end else if (valid_in && singular_in) begin
            singular_err <= 1'b1;
        end
    end

endmodule

/* back_substitute.sv */
`timescale 1ns/10ps

module back_substitute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  solver_pkg::aug_mat_t mat_in,
    input  logic                 singular_in,
    output logic                 valid_out,
    output solver_pkg::beta_t    beta_out,
    output logic                 singular_out
);
    import fixed_point_pkg::*;
    import solver_pkg::*;

    // right-hand side column
    localparam int RHS = N_COLS - 1;

    fx_t  beta2_next;
    fx_t  beta1_next;
    fx_t  beta0_next;
    fx_t  beta2_q;
    fx_t  beta1_q;
    row_t row0_q;
    logic valid_q;
    logic singular_q;

    // --------------------
    // stage one
    // --------------------
    // unit diagonal, no division needed
    assign beta2_next = mat_in[2][RHS];
    assign beta1_next = mat_in[1][RHS] - fx_mul(mat_in[1][2], beta2_next);

    always_ff @(posedge clk) begin
        beta2_q <= beta2_next;
        beta1_q <= beta1_next;
        row0_q  <= mat_in[0];
    end

    // --------------------
    // stage two
    // --------------------
    assign beta0_next = row0_q[RHS] - fx_mul(row0_q[1], beta1_q) - fx_mul(row0_q[2], beta2_q);

    always_ff @(posedge clk) begin
        beta_out[0] <= beta0_next;
        beta_out[1] <= beta1_q;
        beta_out[2] <= beta2_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            singular_q   <= 1'b0;
            valid_out    <= 1'b0;
            singular_out <= 1'b0;
        end else begin
            valid_q      <= valid_in;
            singular_q   <= singular_in;
            valid_out    <= valid_q;
            singular_out <= singular_q;
        end
    end

endmodule

/* row_eliminate.sv */
`timescale 1ns/10ps

module row_eliminate #(
    parameter int COL = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  solver_pkg::aug_mat_t mat_in,
    input  logic                 singular_in,
    output logic                 valid_out,
    output solver_pkg::aug_mat_t mat_out,
    output logic                 singular_out
);
    import fixed_point_pkg::*;
    import solver_pkg::*;

    aug_mat_t cleared;

    // row COL is already normalised, so the factor is just the entry itself
    always_comb begin
        cleared = mat_in;
        for (int r = COL + 1; r < N_ROWS; r++) begin
            for (int c = COL; c < N_COLS; c++) begin
                cleared[r][c] = mat_in[r][c] - fx_mul(mat_in[r][COL], mat_in[COL][c]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            singular_out <= 1'b0;
        end else begin
            valid_out    <= valid_in;
            singular_out <= singular_in;
        end
    end

    always_ff @(posedge clk) begin
        mat_out <= cleared;
    end

endmodule

/* row_normalize.sv */
`timescale 1ns/10ps

module row_normalize #(
    parameter int ROW = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  solver_pkg::aug_mat_t mat_in,
    input  logic                 singular_in,
    output logic                 valid_out,
    output solver_pkg::aug_mat_t mat_out,
    output logic                 singular_out
);
    import fixed_point_pkg::*;
    import solver_pkg::*;

    fx_t      pivot;
    logic     pivot_zero;
    aug_mat_t scaled;

    assign pivot      = mat_in[ROW][ROW];
    assign pivot_zero = (pivot == '0);

    // --------------------
    // divide row by pivot
    // --------------------
    // columns left of the pivot are already zero and stay untouched
    always_comb begin
        scaled = mat_in;
        for (int c = ROW; c < N_COLS; c++) begin
            scaled[ROW][c] = fx_div(mat_in[ROW][c], pivot);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            singular_out <= 1'b0;
        end else begin
            valid_out    <= valid_in;
            // zero pivot marks the item, the saturated row is ignored later
            singular_out <= singular_in | pivot_zero;
        end
    end

    always_ff @(posedge clk) begin
        mat_out <= scaled;
    end

endmodule

/* pivot_select.sv */
`timescale 1ns/10ps

module pivot_select #(
    parameter int COL = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  solver_pkg::aug_mat_t mat_in,
    input  logic                 singular_in,
    output logic                 valid_out,
    output solver_pkg::aug_mat_t mat_out,
    output logic                 singular_out
);
    import fixed_point_pkg::*;
    import solver_pkg::*;

    localparam int ROW_W = $clog2(N_ROWS);

    logic [ROW_W-1:0] pick_row;
    fx_t              best_mag;
    aug_mat_t         swapped;

    // first largest magnitude wins, so ties keep the current row
    always_comb begin
        pick_row = ROW_W'(COL);
        best_mag = fx_abs(mat_in[COL][COL]);
        for (int r = COL + 1; r < N_ROWS; r++) begin
            if (fx_abs(mat_in[r][COL]) > best_mag) begin
                pick_row = ROW_W'(r);
                best_mag = fx_abs(mat_in[r][COL]);
            end
        end
        // whole-row swap
        swapped           = mat_in;
        swapped[COL]      = mat_in[pick_row];
        swapped[pick_row] = mat_in[COL];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            singular_out <= 1'b0;
        end else begin
            valid_out    <= valid_in;
            singular_out <= singular_in;
        end
    end

    always_ff @(posedge clk) begin
        mat_out <= swapped;
    end

endmodule

/* solver_pkg.sv */
package solver_pkg;

    // system dimensions, 3x3 plus the right-hand side column
    localparam int N_ROWS = 3;
    localparam int N_COLS = 4;

    // --------------------
    // payload types
    // --------------------
    // index 0 sits in the low bits: mat[row][col], beta[i]
    typedef fixed_point_pkg::fx_t [N_COLS-1:0] row_t;
    typedef row_t [N_ROWS-1:0] aug_mat_t;
    typedef fixed_point_pkg::fx_t [N_ROWS-1:0] beta_t;

    // --------------------
    // pipeline timing
    // --------------------
    // seven elimination stages, two back-substitution stages, one result stage
    localparam int SOLVE_LATENCY = 10;

    // mean reaches the result stage together with its item
    localparam int MEAN_DELAY = SOLVE_LATENCY - 1;

endpackage

/* fixed_point_pkg.sv */
package fixed_point_pkg;

    // q16.16 number format
    localparam int FX_WIDTH = 32;
    localparam int FX_FRAC  = 16;

    typedef logic signed [FX_WIDTH-1:0] fx_t;

    // saturation limits
    localparam fx_t FX_MAX = {1'b0, {(FX_WIDTH-1){1'b1}}};
    localparam fx_t FX_MIN = {1'b1, {(FX_WIDTH-1){1'b0}}};

    // product rescaled back to q16.16, clamped to the format range
    function automatic fx_t fx_mul(input fx_t a, input fx_t b);
        logic signed [2*FX_WIDTH-1:0] prod;
        logic signed [2*FX_WIDTH-1:0] scaled;
        prod   = a * b;
        scaled = prod >>> FX_FRAC;
        if (scaled > FX_MAX) return FX_MAX;
        if (scaled < FX_MIN) return FX_MIN;
        return scaled[FX_WIDTH-1:0];
    endfunction

    // dividend widened and pre-shifted so the quotient lands in q16.16
    function automatic fx_t fx_div(input fx_t num, input fx_t den);
        logic signed [2*FX_WIDTH-1:0] num_ext;
        logic signed [2*FX_WIDTH-1:0] quot;
        if (den == '0) return num[FX_WIDTH-1] ? FX_MIN : FX_MAX;
        num_ext = num;
        num_ext = num_ext <<< FX_FRAC;
        quot    = num_ext / den;
        if (quot > FX_MAX) return FX_MAX;
        if (quot < FX_MIN) return FX_MIN;
        return quot[FX_WIDTH-1:0];
    endfunction

    // magnitude, most negative value clamps to FX_MAX
    function automatic fx_t fx_abs(input fx_t x);
        if (x == FX_MIN) return FX_MAX;
        return x[FX_WIDTH-1] ? -x : x;
    endfunction

endpackage
